/* source/upPkg.sv */
package upPkg;

	// ====================
	// Widths and memory map
	// ====================
	localparam int dataWidth = 8;
	localparam int addrWidth = 8;
	localparam int memDepth  = 256;

	localparam logic [addrWidth-1:0] debugAddr = 8'd127;
	localparam logic [addrWidth-1:0] dataBase  = 8'h80;
	localparam logic [addrWidth-1:0] loopAddr  = 8'h00;    // Start of the main loop
	localparam logic [addrWidth-1:0] exitAddr  = 8'h10;    // Halt target

	// ====================
	// Encodings
	// ====================
	typedef enum logic [7:0] {
		opNop  = 8'h00,
		opLda  = 8'h01,
		opSta  = 8'h02,
		opAdd  = 8'h03,
		opSub  = 8'h04,
		opAnd  = 8'h05,
		opOr   = 8'h06,
		opXori = 8'h07,
		opIn   = 8'h08,
		opOut  = 8'h09,
		opJmp  = 8'h0A,
		opJz   = 8'h0B,
		opJc   = 8'h0C,
		opHlt  = 8'h0D
	} opcode_t;

	typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluXor, aluPass} aluOp_t;

	typedef enum logic [1:0] {stFetch, stOperand, stExecute, stHalt} state_t;

	// ====================
	// Reset program image
	// ====================
	typedef logic [memDepth-1:0][dataWidth-1:0] image_t;

	// Main loop exits on a zero input, else outputs 3x xor 5A and stores it at 127
	function automatic image_t buildImage();
		image_t img;
		img = '0;
		img[0]  = opIn;
		img[1]  = opJz;
		img[2]  = exitAddr;
		img[3]  = opSta;
		img[4]  = dataBase;    // Temp holds x
		img[5]  = opAdd;
		img[6]  = dataBase;
		img[7]  = opAdd;
		img[8]  = dataBase;
		img[9]  = opXori;
		img[10] = 8'h5A;
		img[11] = opOut;
		img[12] = opSta;
		img[13] = debugAddr;
		img[14] = opJmp;
		img[15] = loopAddr;
		img[exitAddr] = opHlt;
		return img;
	endfunction

	localparam image_t progImage = buildImage();

endpackage

/* source/upAlu.sv */
`timescale 1ns/1ps

module upAlu
	import upPkg::*;
(
	input  aluOp_t               op,
	input  logic [dataWidth-1:0] a,
	input  logic [dataWidth-1:0] b,
	output logic [dataWidth-1:0] result,
	output logic                 carry,
	output logic                 zero
);

	logic [dataWidth:0] wide;

	always_comb begin
		wide = '0;
		case (op)
			aluAdd: begin
				wide = {1'b0, a} + {1'b0, b};
			end
			aluSub: begin
				wide = {1'b0, a} - {1'b0, b};    // Bit 8 is the borrow
			end
			aluAnd: begin
				wide = {1'b0, a & b};
			end
			aluOr: begin
				wide = {1'b0, a | b};
			end
			aluXor: begin
				wide = {1'b0, a ^ b};
			end
			default: begin
				wide = {1'b0, b};    // Pass
			end
		endcase
	end

	assign result = wide[dataWidth-1:0];
	assign carry  = wide[dataWidth];
	assign zero   = (result == '0);

endmodule

/* source/upMemory.sv */
`timescale 1ns/1ps

module upMemory
	import upPkg::*;
(
	input  logic                 clk,
	input  logic                 nRst,
	input  logic [addrWidth-1:0] address,
	input  logic [dataWidth-1:0] wrData,
	input  logic                 we,
	output logic [dataWidth-1:0] rdData,
	output logic [dataWidth-1:0] debug
);

	logic [dataWidth-1:0] mem [memDepth];

	// ====================
	// Storage
	// ====================
	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			for (int i = 0; i < memDepth; i++) begin
				mem[i] <= progImage[i];    // Program reload
			end
		end else if (we) begin
			mem[address] <= wrData;
		end
	end

	assign rdData = mem[address];    // Async read
	assign debug  = mem[debugAddr];

	// ====================
	// Checks
	// ====================
	// Code area is read only, except the result mailbox
	codeWriteCheck: assert property (
		@(posedge clk) disable iff (!nRst)
		we |-> ((address >= dataBase) || (address == debugAddr))
	) else $error("Write into code area at %0h", address);

endmodule

/* source/upProcessor.sv */
`timescale 1ns/1ps

module upProcessor
	import upPkg::*;
(
	input  logic                 clk,
	input  logic                 nRst,
	input  logic [dataWidth-1:0] rdData,
	input  logic [dataWidth-1:0] inPort,
	output logic [addrWidth-1:0] address,
	output logic [dataWidth-1:0] wrData,
	output logic                 we,
	output logic [dataWidth-1:0] outPort,
	output logic                 outStrobe,
	output logic                 halted
);

	state_t               state;
	logic [addrWidth-1:0] pc;
	opcode_t              ir;
	logic [dataWidth-1:0] operand;
	logic [dataWidth-1:0] acc;
	logic                 zFlag;
	logic                 cFlag;
	opcode_t              fetched;
	logic                 needsOperand;
	logic                 memAccess;
	logic                 aluWrite;
	aluOp_t               aluOp;
	logic [dataWidth-1:0] aluB;
	logic [dataWidth-1:0] aluResult;
	logic                 aluCarry;
	logic                 aluZero;

	// ====================
	// Decode
	// ====================
	assign fetched      = opcode_t'(rdData);
	assign needsOperand = !(fetched inside {opNop, opIn, opOut, opHlt});
	assign memAccess    = ir inside {opLda, opSta, opAdd, opSub, opAnd, opOr};

	always_comb begin
		aluOp    = aluPass;
		aluWrite = 1'b0;
		case (ir)
			opLda:   aluWrite = 1'b1;
			opAdd:   begin aluOp = aluAdd; aluWrite = 1'b1; end
			opSub:   begin aluOp = aluSub; aluWrite = 1'b1; end
			opAnd:   begin aluOp = aluAnd; aluWrite = 1'b1; end
			opOr:    begin aluOp = aluOr;  aluWrite = 1'b1; end
			opXori:  begin aluOp = aluXor; aluWrite = 1'b1; end
			default: ;
		endcase
	end

	assign aluB    = (ir == opXori) ? operand : rdData;    // Immediate or memory
	assign address = ((state == stExecute) && memAccess) ? operand : pc;
	assign wrData  = acc;
	assign we      = (state == stExecute) && (ir == opSta);

	upAlu aluI (
		.op     (aluOp),
		.a      (acc),
		.b      (aluB),
		.result (aluResult),
		.carry  (aluCarry),
		.zero   (aluZero)
	);

	// ====================
	// Sequencer
	// ====================
	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			state     <= stFetch;
			pc        <= '0;
			ir        <= opNop;
			operand   <= '0;
			acc       <= '0;
			zFlag     <= 1'b0;
			cFlag     <= 1'b0;
			outPort   <= '0;
			outStrobe <= 1'b0;
			halted    <= 1'b0;
		end else begin
			outStrobe <= 1'b0;    // Single cycle pulse
			case (state)
				stFetch: begin
					ir    <= fetched;
					pc    <= pc + 1'b1;
					state <= needsOperand ? stOperand : stExecute;
				end
				stOperand: begin
					operand <= rdData;
					pc      <= pc + 1'b1;
					state   <= stExecute;
				end
				stExecute: begin
					state <= stFetch;
					if (aluWrite) begin
						acc   <= aluResult;
						zFlag <= aluZero;
						cFlag <= aluCarry;
					end
					case (ir)
						opIn: begin
							acc   <= inPort;
							zFlag <= (inPort == '0);
						end
						opOut: begin
							outPort   <= acc;
							outStrobe <= 1'b1;
						end
						opJmp:   pc <= operand;
						opJz:    if (zFlag) pc <= operand;
						opJc:    if (cFlag) pc <= operand;
						opHlt: begin
							halted <= 1'b1;
							state  <= stHalt;
						end
						default: ;
					endcase
				end
				default: ;    // Halt is terminal
			endcase
		end
	end

	// ====================
	// Checks
	// ====================
	// A store executes only after its address byte was fetched
	weStateCheck: assert property (
		@(posedge clk) disable iff (!nRst) we |-> ($past(state) == stOperand)
	) else $error("Memory write without a preceding operand cycle");

	haltStickyCheck: assert property (
		@(posedge clk) disable iff (!nRst) halted |=> halted
	) else $error("Halted dropped without reset");

endmodule

/* source/upSystem.sv */
`timescale 1ns/1ps

module upSystem
	import upPkg::*;
(
	input  logic                 clk,
	input  logic                 nRst,
	input  logic [dataWidth-1:0] inPort,
	output logic [dataWidth-1:0] outPort,
	output logic                 outStrobe,
	output logic                 halted,
	output logic [dataWidth-1:0] debug
);

	logic [addrWidth-1:0] address;
	logic [dataWidth-1:0] wrData;
	logic [dataWidth-1:0] rdData;
	logic                 we;

	upProcessor procI (
		.clk       (clk),
		.nRst      (nRst),
		.rdData    (rdData),
		.inPort    (inPort),
		.address   (address),
		.wrData    (wrData),
		.we        (we),
		.outPort   (outPort),
		.outStrobe (outStrobe),
		.halted    (halted)
	);

	upMemory memI (
		.clk     (clk),
		.nRst    (nRst),
		.address (address),
		.wrData  (wrData),
		.we      (we),
		.rdData  (rdData),
		.debug   (debug)    // Location 127
	);

endmodule

/* tb/systemChecker.sv */
`timescale 1ns/1ps

module systemChecker
	import upPkg::*;
#(
	parameter int nameBits = 96
) (
	input  logic                 clk,
	input  logic                 nRst,
	input  logic [dataWidth-1:0] outPort,
	input  logic                 outStrobe,
	input  logic                 halted,
	input  logic [dataWidth-1:0] debug,
	input  int                   idx,
	input  int                   tableSize,
	input  logic [dataWidth-1:0] curIn,
	input  logic [nameBits-1:0]  curName,
	input  logic                 runDone,
	output int                   passCount,
	output int                   failCount
);

	int                   strobeCount;
	int                   resetBad;
	bit                   strobeLast;
	bit                   haltSeen;
	bit                   haltDropped;
	bit                   resetDone;
	bit                   finalDone;
	logic [dataWidth-1:0] prevExp;

	// Three times the input, mod 256, then xor 5A
	function automatic logic [dataWidth-1:0] expectedOut(input logic [dataWidth-1:0] x);
		logic [dataWidth-1:0] tripled;
		tripled = x + x + x;
		return tripled ^ 8'h5A;
	endfunction

	task automatic checkValue(input logic [nameBits-1:0] name, input string what,
			input logic [dataWidth-1:0] expected, input logic [dataWidth-1:0] actual);
		if (expected === actual) begin
			passCount++;
			$display("Pass  %s %s = %02h", name, what, actual);
		end else begin
			failCount++;
			$display("Error %s %s: expected %02h, actual %02h", name, what, expected, actual);
		end
	endtask

	task automatic reportProblem(input string msg);
		failCount++;
		$display("Failure: %s", msg);
	endtask

	// ====================
	// Sampling on the falling edge
	// ====================
	always @(negedge clk) begin
		if (!nRst) begin
			if (outStrobe || halted || (outPort != '0) || (debug != '0)) begin
				resetBad++;
			end
		end else begin
			if (!resetDone) begin
				resetDone = 1'b1;
				if (resetBad != 0) begin
					reportProblem("outputs left their reset values while nRst was low");
				end
				checkValue(nameBits'("reset"), "outPort", 8'h00, outPort);
				checkValue(nameBits'("reset"), "debug", 8'h00, debug);
				checkValue(nameBits'("reset"), "outStrobe", 8'h00, {7'b0, outStrobe});
				checkValue(nameBits'("reset"), "halted", 8'h00, {7'b0, halted});
			end
			if (outStrobe && strobeLast) begin
				reportProblem("outStrobe stayed high for more than one cycle");
			end else if (outStrobe) begin
				strobeCount++;
				if (curIn == '0) begin
					reportProblem($sformatf("outStrobe pulsed at zero entry %0d", idx));
				end else begin
					checkValue(curName, "outPort", expectedOut(curIn), outPort);
					if (strobeCount > 1) begin
						checkValue(curName, "debug", prevExp, debug);    // Previous store
					end
					prevExp = expectedOut(curIn);
				end
			end
			strobeLast = outStrobe;
			if (halted && !haltSeen) begin
				haltSeen = 1'b1;
				if (curIn != '0) begin
					reportProblem($sformatf("halted rose at non-zero entry %0d", idx));
				end
				checkValue(nameBits'("halt"), "debug", prevExp, debug);
			end else if (haltSeen && !halted && !haltDropped) begin
				haltDropped = 1'b1;
				reportProblem("halted fell before the end of the run");
			end
			if (runDone && !finalDone) begin
				finalDone = 1'b1;
				if (!haltSeen) begin
					reportProblem("halted never rose");
				end
				if (strobeCount == tableSize - 1) begin
					passCount++;
					$display("Pass  strobe count = %0d", strobeCount);
				end else begin
					failCount++;
					$display("Error strobe count: expected %0d, actual %0d",
						tableSize - 1, strobeCount);
				end
			end
		end
	end

endmodule

/* tb/systemTb.sv */
`timescale 1ns/1ps

module systemTb
	import upPkg::*;
#(
	parameter int randSeed = 99775
) ();

	localparam int clkPeriod      = 100;
	localparam int resetCycles    = 4;
	localparam int fixedCount     = 5;
	localparam int randCount      = 6;
	localparam int numEntries     = fixedCount + randCount + 1;
	localparam int nameBits       = 96;
	localparam int watchdogCycles = numEntries * 40 + resetCycles;

	localparam logic [dataWidth-1:0] fixedIn [fixedCount] = '{
		8'h01, 8'h55, 8'h80, 8'hFF, 8'h2B
	};
	localparam logic [nameBits-1:0] fixedName [fixedCount] = '{
		nameBits'("one"), nameBits'("alt55"), nameBits'("carry80"),
		nameBits'("carryFF"), nameBits'("mixed2B")
	};

	logic                 clk;
	logic                 nRst;
	logic [dataWidth-1:0] inPort;
	logic [dataWidth-1:0] outPort;
	logic                 outStrobe;
	logic                 halted;
	logic [dataWidth-1:0] debug;
	logic                 runDone;
	int                   idx;
	int                   passCount;
	int                   failCount;
	logic [dataWidth-1:0] curIn;
	logic [nameBits-1:0]  curName;
	logic [dataWidth-1:0] stimIn   [numEntries];
	logic [nameBits-1:0]  stimName [numEntries];

	assign curIn   = stimIn[idx];
	assign curName = stimName[idx];

	// ====================
	// Stimulus table
	// ====================
	task automatic buildTable();
		logic [dataWidth-1:0] draw;
		for (int k = 0; k < fixedCount; k++) begin
			stimIn[k]   = fixedIn[k];
			stimName[k] = fixedName[k];
		end
		for (int k = 0; k < randCount; k++) begin
			draw = 8'($urandom());
			while (draw == '0) begin
				draw = 8'($urandom());    // Zero would end the loop early
			end
			stimIn[fixedCount + k]   = draw;
			stimName[fixedCount + k] = nameBits'({"random", 8'(8'h31 + k)});
		end
		stimIn[numEntries - 1]   = 8'h00;
		stimName[numEntries - 1] = nameBits'("zeroExit");
	endtask

	upSystem dut_i (
		.clk       (clk),
		.nRst      (nRst),
		.inPort    (inPort),
		.outPort   (outPort),
		.outStrobe (outStrobe),
		.halted    (halted),
		.debug     (debug)
	);

	systemChecker #(.nameBits(nameBits)) checkerI (
		.clk       (clk),
		.nRst      (nRst),
		.outPort   (outPort),
		.outStrobe (outStrobe),
		.halted    (halted),
		.debug     (debug),
		.idx       (idx),
		.tableSize (numEntries),
		.curIn     (curIn),
		.curName   (curName),
		.runDone   (runDone),
		.passCount (passCount),
		.failCount (failCount)
	);

	initial clk = 1'b0;
	always #(clkPeriod / 2) clk = ~clk;

	initial begin
		nRst    <= 1'b0;
		inPort  <= '0;
		idx     <= 0;
		runDone <= 1'b0;
		void'($urandom(randSeed));
		buildTable();
		repeat (resetCycles) @(posedge clk);
		nRst   <= 1'b1;
		inPort <= stimIn[0];
		while (!halted) begin
			@(posedge clk);
			if (outStrobe && (idx < numEntries - 1)) begin
				idx    <= idx + 1;    // Next byte on the edge that ends the strobe
				inPort <= stimIn[idx + 1];
			end
		end
		repeat (4) @(posedge clk);    // Halt must hold
		runDone <= 1'b1;
		repeat (2) @(posedge clk);
		$display("Checks passed: %0d, failed: %0d", passCount, failCount);
		if ((failCount == 0) && (passCount > 0)) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(watchdogCycles * clkPeriod);
		$display("Timeout: processor did not halt within %0d cycles", watchdogCycles);
		$display("** FAIL **");
		$finish;
	end

endmodule

/* project.f */
source/upPkg.sv
source/upAlu.sv
source/upMemory.sv
source/upProcessor.sv
source/upSystem.sv
tb/systemChecker.sv
tb/systemTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= systemTb
SEED      ?= 99775
BUILD     ?= build

.PHONY: sim clean

# Pass only when the run prints the pass message
sim:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) -GrandSeed=$(SEED) \
		-f project.f --Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP) | tee /dev/stderr | grep -F '** PASS **' > /dev/null

clean:
	rm -rf $(BUILD)
